//--- hdl/svc_settings.svh
/*
  Test-service controller settings
  Command byte codes and the sub-reset hold length
*/
`ifndef SVC_SETTINGS_SVH
`define SVC_SETTINGS_SVH

// --------------------
// Command codes, the high nibble is the group
// --------------------

// AXI user override of the fuse controller write path
`define SVC_CMD_AWUSER_CORE     8'h10
`define SVC_CMD_AWUSER_MCU      8'h11
`define SVC_CMD_AWUSER_RELEASE  8'h12

// Zeroization overrides
`define SVC_CMD_ZEROIZE_ON      8'h20
`define SVC_CMD_ZEROIZE_OFF     8'h21
`define SVC_CMD_ZEROIZE_RELEASE 8'h22

// Life-cycle token and PPD overrides
`define SVC_CMD_LC_TOKENS       8'h30
`define SVC_CMD_RMA_SCRAP_PPD   8'h31

// Escalation triggers
`define SVC_CMD_FC_ESCALATE     8'h40
`define SVC_CMD_LC_ESCALATE0    8'h41
`define SVC_CMD_LC_ESCALATE1    8'h42

// Clock group, low two bits pick 500, 160, 400 or 1000 MHz
`define SVC_GRP_CLK             4'h5

// Fault injection
`define SVC_CMD_FAULT_DIGEST    8'h60
`define SVC_CMD_FAULT_BUS_ECC   8'h61

// Fuse and life-cycle controller reset
`define SVC_CMD_SUB_RESET       8'h70
`define SVC_RST_HOLD_CYCLES     11

`endif

//--- hdl/svc_pkg.sv
/*
  Test-service controller types
  Command byte views, the decoded event and the override bundle
*/
package svc_pkg;

  // Nibble view of a command byte
  typedef struct packed {
    logic [3:0] grp;
    logic [3:0] arg;
  } svc_cmd_fields_t;

  // Exact codes compare against raw, the clock group is read by nibbles
  typedef union packed {
    logic [7:0]      raw;
    svc_cmd_fields_t fields;
  } svc_cmd_u;

  // One decoded command, at most one strobe is set per event
  typedef struct packed {
    logic       awuser_core;
    logic       awuser_mcu;
    logic       awuser_release;
    logic       zeroize_on;
    logic       zeroize_off;
    logic       zeroize_release;
    logic       lc_tokens;
    logic       rma_scrap_ppd;
    logic       fc_escalate;
    logic       lc_escalate0;
    logic       lc_escalate1;
    logic       fault_digest;
    logic       fault_bus_ecc;
    logic       freq_load;
    logic [1:0] freq_code;
    logic       sub_reset;
  } svc_event_t;

  // Override controls read by the rest of the subsystem
  typedef struct packed {
    logic       awuser_ovr_en;
    logic       awuser_sel_mcu;
    logic       zeroize_ovr_en;
    logic       zeroize_val;
    logic       tokens_ovr_en;
    logic       rma_scrap_ppd;
    logic       fc_escalate;
    logic       lc_escalate0;
    logic       lc_escalate1;
    logic       digest_fault;
    logic       bus_ecc_fault;
    logic [1:0] freq_sel;
  } svc_override_t;

endpackage

//--- hdl/svc_cmd_decoder.sv
/*
  Service command decoder
  Captures a strobed command byte and turns it into a one-cycle event
*/
`timescale 1ns/10ps
`include "svc_settings.svh"

module svc_cmd_decoder
  import svc_pkg::*;
(
  input  logic       clk,
  input  logic       cptra_rst_b,
  input  logic       cmd_valid_i,
  input  svc_cmd_u   cmd_i,
  output svc_event_t event_o
);

  logic       cmd_vld_q;
  svc_cmd_u   cmd_q;
  svc_event_t event_d;
  svc_event_t event_q;

  // --------------------
  // Command capture
  // --------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      cmd_vld_q <= 1'b0;
    end else begin
      cmd_vld_q <= cmd_valid_i;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_valid_i) begin
      cmd_q <= cmd_i;
    end
  end

  // --------------------
  // Decode
  // --------------------
  always_comb begin
    event_d = '0;
    if (cmd_vld_q) begin
      case (cmd_q.raw)
        `SVC_CMD_AWUSER_CORE:     event_d.awuser_core     = 1'b1;
        `SVC_CMD_AWUSER_MCU:      event_d.awuser_mcu      = 1'b1;
        `SVC_CMD_AWUSER_RELEASE:  event_d.awuser_release  = 1'b1;
        `SVC_CMD_ZEROIZE_ON:      event_d.zeroize_on      = 1'b1;
        `SVC_CMD_ZEROIZE_OFF:     event_d.zeroize_off     = 1'b1;
        `SVC_CMD_ZEROIZE_RELEASE: event_d.zeroize_release = 1'b1;
        `SVC_CMD_LC_TOKENS:       event_d.lc_tokens       = 1'b1;
        `SVC_CMD_RMA_SCRAP_PPD:   event_d.rma_scrap_ppd   = 1'b1;
        `SVC_CMD_FC_ESCALATE:     event_d.fc_escalate     = 1'b1;
        `SVC_CMD_LC_ESCALATE0:    event_d.lc_escalate0    = 1'b1;
        `SVC_CMD_LC_ESCALATE1:    event_d.lc_escalate1    = 1'b1;
        `SVC_CMD_FAULT_DIGEST:    event_d.fault_digest    = 1'b1;
        `SVC_CMD_FAULT_BUS_ECC:   event_d.fault_bus_ecc   = 1'b1;
        `SVC_CMD_SUB_RESET:       event_d.sub_reset       = 1'b1;
        default: begin
          // Any byte in the clock group loads a frequency code
          if (cmd_q.fields.grp == `SVC_GRP_CLK) begin
            event_d.freq_load = 1'b1;
            event_d.freq_code = cmd_q.fields.arg[1:0];
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      event_q <= '0;
    end else begin
      event_q <= event_d;
    end
  end

  assign event_o = event_q;

endmodule

//--- hdl/svc_override_regs.sv
/*
  Service override registers
  Sticky override state updated by decoded events, with the clock
  frequency select gated by bypass acknowledge
*/
`timescale 1ns/10ps

module svc_override_regs
  import svc_pkg::*;
(
  input  logic          clk,
  input  logic          cptra_rst_b,
  input  svc_event_t    event_i,
  input  logic          clk_byp_ack_i,
  output svc_override_t ovr_o
);

  svc_override_t ovr_q;

  // --------------------
  // Override state
  // --------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      ovr_q <= '0;
    end else begin
      // AXI user source, a set command also picks the source
      if (event_i.awuser_core || event_i.awuser_mcu) begin
        ovr_q.awuser_ovr_en  <= 1'b1;
        ovr_q.awuser_sel_mcu <= event_i.awuser_mcu;
      end else if (event_i.awuser_release) begin
        ovr_q.awuser_ovr_en <= 1'b0;
      end

      // Zeroization, on and off both take over the signal
      if (event_i.zeroize_on) begin
        ovr_q.zeroize_ovr_en <= 1'b1;
        ovr_q.zeroize_val    <= 1'b1;
      end else if (event_i.zeroize_off) begin
        ovr_q.zeroize_ovr_en <= 1'b1;
        ovr_q.zeroize_val    <= 1'b0;
      end else if (event_i.zeroize_release) begin
        ovr_q.zeroize_ovr_en <= 1'b0;
      end

      // Set-only bits, these hold until the next subsystem reset
      ovr_q.tokens_ovr_en <= ovr_q.tokens_ovr_en | event_i.lc_tokens;
      ovr_q.rma_scrap_ppd <= ovr_q.rma_scrap_ppd | event_i.rma_scrap_ppd;
      ovr_q.fc_escalate   <= ovr_q.fc_escalate   | event_i.fc_escalate;
      ovr_q.lc_escalate0  <= ovr_q.lc_escalate0  | event_i.lc_escalate0;
      ovr_q.lc_escalate1  <= ovr_q.lc_escalate1  | event_i.lc_escalate1;
      ovr_q.digest_fault  <= ovr_q.digest_fault  | event_i.fault_digest;
      ovr_q.bus_ecc_fault <= ovr_q.bus_ecc_fault | event_i.fault_bus_ecc;

      // Stored frequency code, kept even while bypass is not acknowledged
      if (event_i.freq_load) begin
        ovr_q.freq_sel <= event_i.freq_code;
      end
    end
  end

  // --------------------
  // Output
  // --------------------

  // The external clock only applies once the life-cycle controller
  // acknowledges bypass, otherwise the default 500 MHz code is shown
  always_comb begin
    ovr_o = ovr_q;
    if (!clk_byp_ack_i) begin
      ovr_o.freq_sel = 2'b00;
    end
  end

endmodule

//--- hdl/svc_reset_timer.sv
/*
  Sub-reset timer
  Drives a counted active-low reset pulse to the fuse and life-cycle
  controllers
*/
`timescale 1ns/10ps
`include "svc_settings.svh"

module svc_reset_timer
  import svc_pkg::*;
(
  input  logic       clk,
  input  logic       cptra_rst_b,
  input  svc_event_t event_i,
  output logic       sub_rst_b_o
);

  localparam int HOLD  = `SVC_RST_HOLD_CYCLES;
  localparam int CNT_W = $clog2(HOLD);

  logic             active_q;
  logic [CNT_W-1:0] cnt_q;

  // Count down the remaining low cycles, a request during the pulse is dropped
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      active_q <= 1'b0;
      cnt_q    <= '0;
    end else if (active_q) begin
      if (cnt_q == '0) begin
        active_q <= 1'b0;
      end else begin
        cnt_q <= cnt_q - 1'b1;
      end
    end else if (event_i.sub_reset) begin
      active_q <= 1'b1;
      cnt_q    <= CNT_W'(HOLD - 1);
    end
  end

  assign sub_rst_b_o = ~active_q;

endmodule

//--- hdl/svc_top.sv
/*
  Test-service controller top level
  Decoder, override registers and sub-reset timer
*/
`timescale 1ns/10ps

module svc_top
  import svc_pkg::*;
(
  input  logic          clk,
  input  logic          cptra_rst_b,
  input  logic          cmd_valid_i,
  input  logic [7:0]    cmd_i,
  input  logic          clk_byp_ack_i,
  output svc_override_t ovr_o,
  output logic          sub_rst_b_o
);

  svc_cmd_u   cmd_u;
  svc_event_t svc_event;

  assign cmd_u = cmd_i;

  // --------------------
  // Input side
  // --------------------
  svc_cmd_decoder svc_cmd_decoder_inst (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .cmd_valid_i (cmd_valid_i),
    .cmd_i       (cmd_u),
    .event_o     (svc_event)
  );

  // --------------------
  // Override state and reset pulse
  // --------------------
  svc_override_regs svc_override_regs_inst (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .event_i       (svc_event),
    .clk_byp_ack_i (clk_byp_ack_i),
    .ovr_o         (ovr_o)
  );

  svc_reset_timer svc_reset_timer_inst (
    .clk         (clk),
    .cptra_rst_b (cptra_rst_b),
    .event_i     (svc_event),
    .sub_rst_b_o (sub_rst_b_o)
  );

endmodule

//--- bench/svc_checker.sv
/*
  Bound checker for the test-service controller
  Shadows the override state and the sub-reset pulse from the command inputs
*/
`timescale 1ns/10ps
`include "svc_settings.svh"

module svc_checker
  import svc_pkg::*;
(
  input logic          clk,
  input logic          cptra_rst_b,
  input logic          cmd_valid_i,
  input logic [7:0]    cmd_i,
  input logic          clk_byp_ack_i,
  input svc_override_t ovr_o,
  input logic          sub_rst_b_o
);

  localparam int HOLD = `SVC_RST_HOLD_CYCLES;

  // Strobe and byte, delayed so a command acts two edges after it is sampled
  logic [8:0]    cmd_d1;
  logic [8:0]    cmd_d2;
  svc_override_t shadow;
  int            rst_left;
  int            n_flags = 0;
  int            n_freq = 0;
  int            n_rst = 0;
  int            fail_total;

  assign fail_total = n_flags + n_freq + n_rst;

  // --------------------
  // Shadow state
  // --------------------
  always_ff @(posedge clk or negedge cptra_rst_b) begin
    if (!cptra_rst_b) begin
      {cmd_d2, cmd_d1} <= '0;
      shadow           <= '0;
      rst_left         <= 0;
    end else begin
      {cmd_d2, cmd_d1} <= {cmd_d1, cmd_valid_i, cmd_i};
      // Low cycles still owed on the sub-reset
      if (rst_left != 0) begin
        rst_left <= rst_left - 1;
      end
      if (cmd_d2[8]) begin
        case (cmd_d2[7:0])
          `SVC_CMD_AWUSER_CORE:     {shadow.awuser_ovr_en, shadow.awuser_sel_mcu} <= 2'b10;
          `SVC_CMD_AWUSER_MCU:      {shadow.awuser_ovr_en, shadow.awuser_sel_mcu} <= 2'b11;
          `SVC_CMD_AWUSER_RELEASE:  shadow.awuser_ovr_en <= 1'b0;
          `SVC_CMD_ZEROIZE_ON:      {shadow.zeroize_ovr_en, shadow.zeroize_val} <= 2'b11;
          `SVC_CMD_ZEROIZE_OFF:     {shadow.zeroize_ovr_en, shadow.zeroize_val} <= 2'b10;
          `SVC_CMD_ZEROIZE_RELEASE: shadow.zeroize_ovr_en <= 1'b0;
          `SVC_CMD_LC_TOKENS:       shadow.tokens_ovr_en <= 1'b1;
          `SVC_CMD_RMA_SCRAP_PPD:   shadow.rma_scrap_ppd <= 1'b1;
          `SVC_CMD_FC_ESCALATE:     shadow.fc_escalate <= 1'b1;
          `SVC_CMD_LC_ESCALATE0:    shadow.lc_escalate0 <= 1'b1;
          `SVC_CMD_LC_ESCALATE1:    shadow.lc_escalate1 <= 1'b1;
          `SVC_CMD_FAULT_DIGEST:    shadow.digest_fault <= 1'b1;
          `SVC_CMD_FAULT_BUS_ECC:   shadow.bus_ecc_fault <= 1'b1;
          `SVC_CMD_SUB_RESET: begin
            // A request inside a running pulse is dropped
            if (rst_left == 0) begin
              rst_left <= HOLD;
            end
          end
          default: begin
            if (cmd_d2[7:4] == `SVC_GRP_CLK) begin
              shadow.freq_sel <= cmd_d2[1:0];
            end
          end
        endcase
      end
    end
  end

  // --------------------
  // Assertions
  // --------------------
  a_flags: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    ovr_o[12:2] == shadow[12:2])
    else begin
      n_flags = n_flags + 1;
      $error("[FAIL] ovr_o flags exp %h got %h", $sampled(shadow[12:2]), $sampled(ovr_o[12:2]));
    end

  a_freq: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    ovr_o.freq_sel == (clk_byp_ack_i ? shadow.freq_sel : 2'b00))
    else begin
      n_freq = n_freq + 1;
      $error("[FAIL] ovr_o.freq_sel exp %h got %h (bypass ack %h)",
             $sampled(clk_byp_ack_i ? shadow.freq_sel : 2'b00),
             $sampled(ovr_o.freq_sel), $sampled(clk_byp_ack_i));
    end

  a_sub_rst: assert property (@(posedge clk) disable iff (!cptra_rst_b)
    sub_rst_b_o == (rst_left == 0))
    else begin
      n_rst = n_rst + 1;
      $error("[FAIL] sub_rst_b_o exp %h got %h", $sampled(rst_left == 0), $sampled(sub_rst_b_o));
    end

endmodule

bind svc_top svc_checker svc_checker_inst (.*);

//--- bench/svc_tb.sv
/*
  Testbench for the test-service controller
  Directed and random command streams, checked by the bound assertions
*/
`timescale 1ns/10ps
`include "svc_settings.svh"

module svc_tb
  import svc_pkg::*;
();

  // Directed tests take about 150 cycles and the random stream at most 800
  localparam int RAND_CMDS      = 200;
  localparam int TIMEOUT_CYCLES = 2000;

  logic          clk;
  logic          cptra_rst_b;
  logic          cmd_valid;
  logic [7:0]    cmd;
  logic          clk_byp_ack;
  svc_override_t ovr;
  logic          sub_rst_b;
  int            seed;
  int            cycles = 0;
  int            tests_run = 0;
  int            tests_failed = 0;
  int            fails_seen = 0;

  svc_top svc_top_inst (
    .clk           (clk),
    .cptra_rst_b   (cptra_rst_b),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .clk_byp_ack_i (clk_byp_ack),
    .ovr_o         (ovr),
    .sub_rst_b_o   (sub_rst_b)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles = cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("STATUS: FAIL");
      $finish;
    end
  end

  // Strobe one command, then leave the bus idle for gap cycles
  task automatic issue(input logic [7:0] code, input int gap);
    @(negedge clk);
    cmd_valid = 1'b1;
    cmd       = code;
    repeat (gap) begin
      @(negedge clk);
      cmd_valid = 1'b0;
    end
  endtask

  task automatic wait_reset_release();
    cmd_valid = 1'b0;
    while (sub_rst_b !== 1'b1) begin
      @(negedge clk);
    end
  endtask

  // Outputs move two edges after the last strobe and are checked one edge later
  task automatic end_test(input string name);
    int fails;
    cmd_valid = 1'b0;
    repeat (4) @(negedge clk);
    fails      = svc_top_inst.svc_checker_inst.fail_total - fails_seen;
    fails_seen = fails_seen + fails;
    tests_run  = tests_run + 1;
    if (fails == 0) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed = tests_failed + 1;
      $display("test %s: %0d assertion failures", name, fails);
    end
  endtask

  initial begin
    logic [31:0] rnd;
    logic [7:0]  code;
    seed        = 32'h8b10d8f8;
    cptra_rst_b = 1'b0;
    cmd_valid   = 1'b0;
    cmd         = 8'h00;
    clk_byp_ack = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    cptra_rst_b = 1'b1;

    issue(`SVC_CMD_AWUSER_CORE, 3);
    issue(`SVC_CMD_AWUSER_MCU, 3);
    issue(`SVC_CMD_AWUSER_RELEASE, 3);
    end_test("awuser");

    issue(`SVC_CMD_ZEROIZE_ON, 3);
    issue(`SVC_CMD_ZEROIZE_OFF, 3);
    issue(`SVC_CMD_ZEROIZE_RELEASE, 3);
    end_test("zeroize");

    // Set-only bits one at a time, then unrelated traffic back to back
    issue(`SVC_CMD_LC_TOKENS, 3);
    issue(`SVC_CMD_RMA_SCRAP_PPD, 3);
    issue(`SVC_CMD_FC_ESCALATE, 3);
    issue(`SVC_CMD_LC_ESCALATE0, 3);
    issue(`SVC_CMD_LC_ESCALATE1, 3);
    issue(`SVC_CMD_FAULT_DIGEST, 3);
    issue(`SVC_CMD_FAULT_BUS_ECC, 3);
    issue(`SVC_CMD_AWUSER_MCU, 0);
    issue(`SVC_CMD_ZEROIZE_ON, 3);
    end_test("sticky");

    for (int k = 0; k < 4; k++) begin
      issue({`SVC_GRP_CLK, 2'b00, k[1:0]}, 3);
      clk_byp_ack = 1'b1;
      repeat (3) @(negedge clk);
      clk_byp_ack = 1'b0;
    end
    end_test("freq");

    // The second request lands inside the running pulse
    issue(`SVC_CMD_SUB_RESET, 5);
    issue(`SVC_CMD_SUB_RESET, 1);
    wait_reset_release();
    end_test("subreset");

    for (int i = 0; i < RAND_CMDS; i++) begin
      rnd = $random(seed);
      // Half the draws stay near the command map, holes included
      if (rnd[8]) begin
        code = {1'b0, rnd[14:12], 2'b00, rnd[1:0]};
      end else begin
        code = rnd[7:0];
      end
      issue(code, int'(rnd[10:9]));
      clk_byp_ack = rnd[20];
    end
    wait_reset_release();
    end_test("random");

    $display("tests: %0d run, %0d failed, %0d assertion failures",
             tests_run, tests_failed, fails_seen);
    if (tests_failed == 0 && fails_seen == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

//--- files.f
+incdir+hdl
hdl/svc_pkg.sv
hdl/svc_cmd_decoder.sv
hdl/svc_override_regs.sv
hdl/svc_reset_timer.sv
hdl/svc_top.sv
bench/svc_checker.sv
bench/svc_tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert
TOP       := svc_tb
FILELIST  := files.f
OBJ_DIR   := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)
	-./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "STATUS: FAIL" $(LOG); then echo "Result: failed"; exit 1; \
	elif grep -q "STATUS: PASS" $(LOG); then echo "Result: passed"; \
	else echo "Result: no status line in $(LOG)"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
